//--- project.f
rtl/cache_pkg.sv
rtl/ahb_read_port.sv
rtl/cache_lines.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
sim/tb_cache.sv

//--- Bender.yml
package:
  name: cache

sources:
  - files:
      - rtl/cache_pkg.sv
      - rtl/ahb_read_port.sv
      - rtl/cache_lines.sv
      - rtl/cache_ctrl.sv
      - rtl/cache_top.sv
  - target: simulation
    files:
      - sim/tb_cache.sv

//--- sim/tb_cache.sv
`default_nettype none

module tb_cache;

    localparam int          max_cycles = 200 * 8 + 200;
    localparam logic [31:0] mem_key    = 32'h5A5A_C3C3;

    logic                               cpu_intf = 1'b0;
    logic                               rst_n;
    cache_pkg::ahb_req_t                ahb_req;
    cache_pkg::ahb_rsp_t                ahb_rsp;
    cache_pkg::mem_req_t                mem_req;
    logic                               mem_req_valid;
    logic                               mem_req_ready;
    cache_pkg::mem_rsp_t                mem_rsp;
    logic                               mem_rsp_valid;
    logic                               mem_rsp_ready;
    logic [cache_pkg::cnt_w-1:0]        hit_count;
    logic [cache_pkg::cnt_w-1:0]        miss_count;

    integer                             seed = 51125;
    int                                 n_checks;
    int                                 n_errors;
    int                                 cycles;
    logic [31:0]                        rd_addr [0:199];
    logic                               ref_valid [16];
    logic [cache_pkg::tag_w-1:0]        ref_tag [16];
    int                                 exp_hits;
    int                                 exp_misses;

    bit                                 req_fire;
    bit                                 rsp_fire;
    bit                                 rsp_pend;
    int                                 rsp_wait;
    int                                 req_count;
    logic [31:0]                        req_addr_q;
    logic [31:0]                        last_req_addr;

    cache_top dut0 (
        .cpu_intf      (cpu_intf),
        .rst_n         (rst_n),
        .ahb_req       (ahb_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid),
        .ahb_rsp       (ahb_rsp),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .hit_count     (hit_count),
        .miss_count    (miss_count)
    );

    always #20 cpu_intf = ~cpu_intf;

    // ########################################
    // memory model
    // ########################################

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ mem_key;
    endfunction

    // handshakes seen at a rising edge are acted on at the next falling edge.
    always @(negedge cpu_intf) begin
        if (req_fire) begin
            req_count     = req_count + 1;
            last_req_addr = req_addr_q;
            rsp_pend      = 1'b1;
            rsp_wait      = {$random(seed)} % 4;
        end
        if (rsp_fire) begin
            mem_rsp_valid = 1'b0;
        end
        if (rsp_pend) begin
            if (rsp_wait == 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp.data  = model_word(last_req_addr);
                rsp_pend      = 1'b0;
            end else begin
                rsp_wait = rsp_wait - 1;
            end
        end
        mem_req_ready = ({$random(seed)} % 4) != 0;
        req_fire      = mem_req_valid && mem_req_ready;
        req_addr_q    = mem_req.addr;
        rsp_fire      = mem_rsp_valid && mem_rsp_ready;
    end

    // ########################################
    // helpers
    // ########################################

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        n_checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s (got %h, expected %h)", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic predict_access(input logic [31:0] addr, output logic is_hit);
        logic [3:0] idx;
        idx    = addr[5:2];
        is_hit = ref_valid[idx] && (ref_tag[idx] == addr[31:6]);
        if (is_hit) begin
            exp_hits++;
        end else begin
            exp_misses++;
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = addr[31:6];
        end
    endtask

    task automatic check_counters(input string what);
        check_equal(hit_count, exp_hits, {what, ": hit_count"});
        check_equal(miss_count, exp_misses, {what, ": miss_count"});
        check_equal(req_count, exp_misses, {what, ": memory requests"});
    endtask

    task automatic present_read(input logic [31:0] addr);
        ahb_req.hsel   = 1'b1;
        ahb_req.haddr  = addr;
        ahb_req.hwrite = 1'b0;
        ahb_req.htrans = cache_pkg::NONSEQ;
        ahb_req.hsize  = 3'b010;
    endtask

    task automatic present_idle();
        ahb_req.hsel   = 1'b0;
        ahb_req.hwrite = 1'b0;
        ahb_req.htrans = cache_pkg::IDLE;
    endtask

    // back-to-back reads; the next address goes out in the last data cycle.
    task automatic run_reads(input int n);
        int          next;
        int          waits;
        logic        busy;
        logic        head_hit;
        logic [31:0] head_addr;
        next  = 0;
        waits = 0;
        busy  = 1'b0;
        while (next < n || busy) begin
            @(negedge cpu_intf);
            if (busy && ahb_rsp.hready) begin
                check_equal(ahb_rsp.hrdata, model_word(head_addr),
                            $sformatf("read data at %h", head_addr));
                check_equal(ahb_rsp.hresp, cache_pkg::OKAY, "read response");
                check_equal(waits == 0, head_hit, $sformatf("wait states at %h", head_addr));
                busy = 1'b0;
            end else if (busy) begin
                waits++;
            end
            if (next < n) begin
                present_read(rd_addr[next]);
                if (ahb_rsp.hready) begin
                    head_addr = rd_addr[next];
                    predict_access(head_addr, head_hit);
                    waits = 0;
                    busy  = 1'b1;
                    next++;
                end
            end else begin
                present_idle();
            end
        end
        @(negedge cpu_intf); // hit_count moves at the edge after the last hit.
    endtask

    // ########################################
    // tests
    // ########################################

    task automatic test_reset_state();
        check_equal(ahb_rsp.hready, 1'b1, "hready after reset");
        check_equal(ahb_rsp.hresp, cache_pkg::OKAY, "hresp after reset");
        check_equal(mem_req_valid, 1'b0, "mem_req_valid after reset");
        check_equal(mem_rsp_ready, 1'b0, "mem_rsp_ready after reset");
        check_equal(hit_count, 0, "hit_count after reset");
        check_equal(miss_count, 0, "miss_count after reset");
    endtask

    task automatic test_miss_then_hit();
        rd_addr[0] = 32'hA40;
        run_reads(1);
        check_equal(req_count, 1, "cold miss request count");
        check_equal(last_req_addr, 32'hA40, "cold miss request address");
        run_reads(1);
        check_equal(req_count, 1, "no request on hit");
        check_equal(hit_count, 1, "hit_count after hit");
        check_equal(miss_count, 1, "miss_count after cold miss");
    endtask

    task automatic test_conflict();
        int reqs_before;
        reqs_before = req_count;
        rd_addr[0]  = 32'hA80; // same index as 0xA40, other tag.
        rd_addr[1]  = 32'hA40;
        rd_addr[2]  = 32'hA80;
        run_reads(3);
        check_equal(req_count - reqs_before, 3, "eviction requests");
        check_counters("conflict eviction");
    endtask

    task automatic test_pipelined();
        int i;
        for (i = 0; i < 16; i++) begin
            rd_addr[i] = 32'hA00 + ((i * 5) % 8) * 4 + (i % 3) * 64;
        end
        run_reads(16);
        check_counters("pipelined reads");
    endtask

    task automatic test_write_error();
        int          reqs_before;
        logic [15:0] hits_before;
        logic [15:0] misses_before;
        reqs_before   = req_count;
        hits_before   = hit_count;
        misses_before = miss_count;
        check_equal(ahb_rsp.hready, 1'b1, "hready before write");
        present_read(32'hA44);
        ahb_req.hwrite = 1'b1;
        @(negedge cpu_intf);
        present_idle();
        check_equal(ahb_rsp.hready, 1'b0, "write first cycle hready");
        check_equal(ahb_rsp.hresp, cache_pkg::ERROR, "write first cycle hresp");
        @(negedge cpu_intf);
        check_equal(ahb_rsp.hready, 1'b1, "write second cycle hready");
        check_equal(ahb_rsp.hresp, cache_pkg::ERROR, "write second cycle hresp");
        @(negedge cpu_intf);
        check_equal(ahb_rsp.hresp, cache_pkg::OKAY, "hresp after write");
        check_equal(req_count, reqs_before, "no request on write");
        check_equal(hit_count, hits_before, "hit_count after write");
        check_equal(miss_count, misses_before, "miss_count after write");
        rd_addr[0] = 32'hA44;
        run_reads(1);
        check_counters("read after write");
    endtask

    task automatic test_random_mix();
        logic [31:0] recent [4];
        int          i;
        for (i = 0; i < 4; i++) begin
            recent[i] = 32'hA00 + i * 4;
        end
        for (i = 0; i < 150; i++) begin
            if ({$random(seed)} % 2 == 0) begin
                rd_addr[i] = recent[{$random(seed)} % 4];
            end else begin
                rd_addr[i] = 32'hA00 + ({$random(seed)} % 64) * 4;
            end
            recent[i % 4] = rd_addr[i];
        end
        run_reads(150);
        check_counters("random mix");
    endtask

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge cpu_intf);
            cycles++;
        end
        $display("Timeout: a handshake with the DUT did not finish within %0d cycles", max_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        ahb_req       = '0;
        mem_req_ready = 1'b0;
        mem_rsp       = '0;
        mem_rsp_valid = 1'b0;
        rst_n         = 1'b0;
        for (int i = 0; i < 16; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        repeat (5) @(negedge cpu_intf);
        rst_n = 1'b1;
        test_reset_state();
        test_miss_then_hit();
        test_conflict();
        test_pipelined();
        test_write_error();
        test_random_mix();
        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/cache_top.sv
`default_nettype none

module cache_top (
    input  logic                         cpu_intf,
    input  logic                         rst_n,
    input  cache_pkg::ahb_req_t          ahb_req,
    input  logic                         mem_req_ready,
    input  cache_pkg::mem_rsp_t          mem_rsp,
    input  logic                         mem_rsp_valid,
    output cache_pkg::ahb_rsp_t          ahb_rsp,
    output cache_pkg::mem_req_t          mem_req,
    output logic                         mem_req_valid,
    output logic                         mem_rsp_ready,
    output logic [cache_pkg::cnt_w-1:0]  hit_count,
    output logic [cache_pkg::cnt_w-1:0]  miss_count
);

    cache_pkg::xfer_t              xfer;
    logic                          xfer_valid;
    logic                          xfer_done;
    logic [cache_pkg::data_w-1:0]  rd_data;
    logic [cache_pkg::addr_w-1:0]  lookup_addr;
    logic                          hit;
    logic [cache_pkg::data_w-1:0]  line_data;
    cache_pkg::fill_t              fill;
    logic                          fill_en;

    ahb_read_port port0 (
        .cpu_intf   (cpu_intf),
        .rst_n      (rst_n),
        .ahb_req    (ahb_req),
        .xfer_done  (xfer_done),
        .rd_data    (rd_data),
        .ahb_rsp    (ahb_rsp),
        .xfer       (xfer),
        .xfer_valid (xfer_valid)
    );

    cache_ctrl ctrl0 (
        .cpu_intf      (cpu_intf),
        .rst_n         (rst_n),
        .xfer          (xfer),
        .xfer_valid    (xfer_valid),
        .hit           (hit),
        .line_data     (line_data),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid),
        .lookup_addr   (lookup_addr),
        .xfer_done     (xfer_done),
        .rd_data       (rd_data),
        .fill          (fill),
        .fill_en       (fill_en),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .hit_count     (hit_count),
        .miss_count    (miss_count)
    );

    cache_lines lines0 (
        .cpu_intf    (cpu_intf),
        .rst_n       (rst_n),
        .lookup_addr (lookup_addr),
        .fill        (fill),
        .fill_en     (fill_en),
        .hit         (hit),
        .line_data   (line_data)
    );

endmodule

`default_nettype wire

//--- rtl/cache_ctrl.sv
`default_nettype none

module cache_ctrl (
    input  logic                          cpu_intf,
    input  logic                          rst_n,
    input  cache_pkg::xfer_t              xfer,
    input  logic                          xfer_valid,
    input  logic                          hit,
    input  logic [cache_pkg::data_w-1:0]  line_data,
    input  logic                          mem_req_ready,
    input  cache_pkg::mem_rsp_t           mem_rsp,
    input  logic                          mem_rsp_valid,
    output logic [cache_pkg::addr_w-1:0]  lookup_addr,
    output logic                          xfer_done,
    output logic [cache_pkg::data_w-1:0]  rd_data,
    output cache_pkg::fill_t              fill,
    output logic                          fill_en,
    output cache_pkg::mem_req_t           mem_req,
    output logic                          mem_req_valid,
    output logic                          mem_rsp_ready,
    output logic [cache_pkg::cnt_w-1:0]   hit_count,
    output logic [cache_pkg::cnt_w-1:0]   miss_count
);

    cache_pkg::ctrl_state_e        state;
    cache_pkg::ctrl_state_e        state_nxt;
    logic                          rd_req;
    logic                          miss_seen;
    logic                          refill_q; // last cycle wrote the line for this read.
    logic [cache_pkg::data_w-1:0]  rsp_data_q;

    assign rd_req    = xfer_valid && !xfer.is_write;
    assign miss_seen = (state == cache_pkg::ST_IDLE) && rd_req && !hit;

    // ########################################
    // state machine
    // ########################################

    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::ST_IDLE:      if (miss_seen) state_nxt = cache_pkg::ST_MISS_REQ;
            cache_pkg::ST_MISS_REQ:  if (mem_req_ready) state_nxt = cache_pkg::ST_MISS_WAIT;
            cache_pkg::ST_MISS_WAIT: if (mem_rsp_valid) state_nxt = cache_pkg::ST_FILL;
            default:                 state_nxt = cache_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            state      <= cache_pkg::ST_IDLE;
            refill_q   <= 1'b0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            state    <= state_nxt;
            refill_q <= (state == cache_pkg::ST_FILL);
            if (xfer_done && !refill_q) hit_count <= hit_count + 1'b1;
            if (miss_seen) miss_count <= miss_count + 1'b1;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (mem_rsp_valid && mem_rsp_ready) begin
            rsp_data_q <= mem_rsp.data;
        end
    end

    // ########################################
    // outputs
    // ########################################

    always_comb begin
        lookup_addr   = xfer.addr;
        xfer_done     = (state == cache_pkg::ST_IDLE) && rd_req && hit;
        rd_data       = line_data;
        mem_req.addr  = {xfer.addr[cache_pkg::addr_w-1:2], 2'b00};
        mem_req_valid = (state == cache_pkg::ST_MISS_REQ);
        mem_rsp_ready = (state == cache_pkg::ST_MISS_WAIT);
        fill_en       = (state == cache_pkg::ST_FILL);
        fill.index    = xfer.addr[cache_pkg::index_w+1:2];
        fill.tag      = xfer.addr[cache_pkg::addr_w-1:cache_pkg::addr_w-cache_pkg::tag_w];
        fill.data     = rsp_data_q;
    end

    a_req_hold : assert property (@(posedge cpu_intf) disable iff (!rst_n)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)));

    // the response side opens only once the request has been taken.
    a_rsp_ready_wait : assert property (@(posedge cpu_intf) disable iff (!rst_n)
        $rose(mem_rsp_ready) |-> $past(mem_req_valid && mem_req_ready));

endmodule

`default_nettype wire

//--- rtl/cache_lines.sv
`default_nettype none

module cache_lines (
    input  logic                          cpu_intf,
    input  logic                          rst_n,
    input  logic [cache_pkg::addr_w-1:0]  lookup_addr,
    input  cache_pkg::fill_t              fill,
    input  logic                          fill_en,
    output logic                          hit,
    output logic [cache_pkg::data_w-1:0]  line_data
);

    logic [cache_pkg::num_lines-1:0] valid_q;
    logic [cache_pkg::tag_w-1:0]     tag_q  [cache_pkg::num_lines];
    logic [cache_pkg::data_w-1:0]    data_q [cache_pkg::num_lines];

    logic [cache_pkg::index_w-1:0]   lk_index;
    logic [cache_pkg::tag_w-1:0]     lk_tag;

    // ########################################
    // lookup
    // ########################################

    assign lk_index = lookup_addr[cache_pkg::index_w+1:2];
    assign lk_tag   = lookup_addr[cache_pkg::addr_w-1:cache_pkg::addr_w-cache_pkg::tag_w];

    always_comb begin
        hit       = valid_q[lk_index] && (tag_q[lk_index] == lk_tag);
        line_data = data_q[lk_index]; // only meaningful together with hit.
    end

    // ########################################
    // storage
    // ########################################

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[fill.index] <= 1'b1;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (fill_en) begin
            tag_q[fill.index]  <= fill.tag;
            data_q[fill.index] <= fill.data;
        end
    end

    a_fill_index_known : assert property (@(posedge cpu_intf) disable iff (!rst_n)
        fill_en |-> !$isunknown(fill.index));

endmodule

`default_nettype wire

//--- rtl/ahb_read_port.sv
`default_nettype none

module ahb_read_port (
    input  logic                          cpu_intf,
    input  logic                          rst_n,
    input  cache_pkg::ahb_req_t           ahb_req,
    input  logic                          xfer_done,
    input  logic [cache_pkg::data_w-1:0]  rd_data,
    output cache_pkg::ahb_rsp_t           ahb_rsp,
    output cache_pkg::xfer_t              xfer,
    output logic                          xfer_valid
);

    logic             hready_int;
    logic             addr_active;
    logic             rd_pend;   // a read is in its data phase.
    logic             err_first; // first error cycle, hready low.
    logic             err_second;
    cache_pkg::xfer_t xfer_q;

    assign addr_active = ahb_req.hsel &&
                         (ahb_req.htrans == cache_pkg::NONSEQ ||
                          ahb_req.htrans == cache_pkg::SEQ);

    // ########################################
    // data phase tracking
    // ########################################

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend    <= 1'b0;
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else begin
            if (hready_int) begin
                rd_pend   <= addr_active && !ahb_req.hwrite;
                err_first <= addr_active && ahb_req.hwrite;
            end else begin
                err_first <= 1'b0; // only ever one wait cycle for an error.
            end
            err_second <= err_first;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (hready_int) begin
            xfer_q.addr     <= ahb_req.haddr;
            xfer_q.is_write <= ahb_req.hwrite;
        end
    end

    // a pending read holds the bus until the controller finishes it.
    assign hready_int = !err_first && (!rd_pend || xfer_done);

    always_comb begin
        ahb_rsp.hrdata = rd_data;
        ahb_rsp.hready = hready_int;
        ahb_rsp.hresp  = (err_first || err_second) ? cache_pkg::ERROR : cache_pkg::OKAY;
    end

    assign xfer       = xfer_q;
    assign xfer_valid = rd_pend;

    // ########################################
    // checks
    // ########################################

    a_err_two_cycle : assert property (@(posedge cpu_intf) disable iff (!rst_n)
        (ahb_rsp.hresp == cache_pkg::ERROR && ahb_rsp.hready) |->
        $past(ahb_rsp.hresp == cache_pkg::ERROR && !ahb_rsp.hready));

    a_no_read_in_err : assert property (@(posedge cpu_intf) disable iff (!rst_n)
        (err_first || err_second) |-> !xfer_valid);

endmodule

`default_nettype wire

//--- rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // ########################################
    // widths and geometry
    // ########################################

    localparam int addr_w    = 32;
    localparam int data_w    = 32;
    localparam int index_w   = 4;  // line index sits in address bits 5 down to 2.
    localparam int num_lines = 16;
    localparam int tag_w     = 26; // tag is address bits 31 down to 6.
    localparam int cnt_w     = 16;

    // ########################################
    // encodings
    // ########################################

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_e;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'b00,
        ST_MISS_REQ  = 2'b01,
        ST_MISS_WAIT = 2'b10,
        ST_FILL      = 2'b11
    } ctrl_state_e;

    // ########################################
    // bundles
    // ########################################

    typedef struct packed {
        logic              hsel;
        logic [addr_w-1:0] haddr;
        logic              hwrite;
        htrans_e           htrans;
        logic [2:0]        hsize;
    } ahb_req_t;

    typedef struct packed {
        logic [data_w-1:0] hrdata;
        logic              hready;
        hresp_e            hresp;
    } ahb_rsp_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              is_write;
    } xfer_t;

    typedef struct packed {
        logic [addr_w-1:0] addr; // word aligned byte address.
    } mem_req_t;

    typedef struct packed {
        logic [data_w-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic [index_w-1:0] index;
        logic [tag_w-1:0]   tag;
        logic [data_w-1:0]  data;
    } fill_t;

endpackage

`default_nettype wire
